//--- filelist.f
+incdir+hw
+incdir+verification
hw/rob_entry_pkg.sv
hw/rob_ctrl_pkg.sv
hw/rob_head_ptrs.sv
hw/rob_tail_ptrs.sv
hw/rob_entry_array.sv
hw/rob_commit_ctrl.sv
hw/rob_top.sv
verification/rob_tb.sv

//--- hw/rob_commit_ctrl.sv
/*
 * rob_commit_ctrl
 *   picks the group of head entries that retire each cycle
 *   run / flush FSM around mispredicted branches
 */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_commit_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	input  rob_entry_pkg::entry_state_e   head_state0,
	input  rob_entry_pkg::entry_state_e   head_state1,
	input  rob_entry_pkg::op_class_e      head_op0,
	input  rob_entry_pkg::op_class_e      head_op1,
	input  logic                          head_mispredict0,
	input  logic                          head_mispredict1,
	input  logic                          commit_ready,
	output logic [`ROB_WIDTH-1:0]         commit_valid,
	output rob_ctrl_pkg::commit_amt_t     commit_amt,
	output logic                          flush
);

	rob_ctrl_pkg::commit_state_e state;
	rob_ctrl_pkg::commit_state_e state_nxt;

	logic run;
	logic grant0;
	logic grant1;
	logic bad_br0;
	logic bad_br1;
	logic two_stores;
	logic retire;
	logic retire_bad_br;

	assign run = (state == rob_ctrl_pkg::cst_run);

	// a mispredict flag only matters on a branch
	assign bad_br0 = (head_op0 == rob_entry_pkg::op_branch) && head_mispredict0;
	assign bad_br1 = (head_op1 == rob_entry_pkg::op_branch) && head_mispredict1;

	// only one store may leave per cycle
	assign two_stores = (head_op0 == rob_entry_pkg::op_store) &&
		(head_op1 == rob_entry_pkg::op_store);

	// ==================================================================
	// group selection
	// ==================================================================
	// the oldest entry retires as soon as it is done
	assign grant0 = run && (head_state0 == rob_entry_pkg::ent_done);

	// the second entry rides along unless the first one ends the group
	assign grant1 = grant0 && !bad_br0 && !two_stores &&
		(head_state1 == rob_entry_pkg::ent_done);

	assign commit_valid = {grant1, grant0};
	assign retire       = grant0 && commit_ready;

	always_comb begin
		commit_amt = '0;
		if (retire)
			commit_amt = grant1 ? rob_ctrl_pkg::commit_amt_t'(2) :
				rob_ctrl_pkg::commit_amt_t'(1)
		;
	end

	// a bad branch is always the last lane of its group
	assign retire_bad_br = retire && (grant1 ? bad_br1 : bad_br0);

	// ==================================================================
	// FSM
	// ==================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			rob_ctrl_pkg::cst_run: begin
				if (retire_bad_br)
					state_nxt = rob_ctrl_pkg::cst_flush;
			end
			// flushing takes one cycle and then normal retirement resumes
			rob_ctrl_pkg::cst_flush: begin
				state_nxt = rob_ctrl_pkg::cst_run;
			end
			default: begin
				state_nxt = rob_ctrl_pkg::cst_run;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= rob_ctrl_pkg::cst_run;
		else
			state <= state_nxt;
	end

	assign flush = (state == rob_ctrl_pkg::cst_flush);

	// nothing leaves the buffer unless the retire side accepts it
	a_amt_needs_ready: assert property (
		@(posedge clk) disable iff (rst)
		(commit_amt != '0) |-> commit_ready
	) else $error("entries retired without commit_ready");

endmodule

//--- hw/rob_config.svh
/*
 * reorder buffer configuration macros
 *   entry count and tag width
 *   dispatch and commit lane count
 *   result and destination register widths
 */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// number of ROB entries, any power of two from 4 up
`define ROB_ENTRIES 16
// tag width, log2 of the entry count
`define ROB_TAG_W 4
// lanes per cycle for both dispatch and commit
`define ROB_WIDTH 2
// width of a writeback result
`define ROB_DATA_W 32
// width of an architectural destination register number
`define ROB_REG_W 5

`endif

//--- hw/rob_ctrl_pkg.sv
/*
 * types used by the commit controller
 *   commit_state_e  run / flush FSM state
 *   commit_amt_t    number of lanes retired in one cycle
 */
`include "rob_config.svh"

package rob_ctrl_pkg;

	// the controller normally runs; a flush cycle follows a
	// mispredicted branch and lasts exactly one clock
	typedef enum logic {
		cst_run   = 1'b0,
		cst_flush = 1'b1
	} commit_state_e;

	// wide enough to count from zero up to the full lane count
	typedef logic [$clog2(`ROB_WIDTH + 1)-1:0] commit_amt_t;

endpackage

//--- hw/rob_entry_array.sv
/*
 * rob_entry_array
 *   per-entry state, op class, destination, result and mispredict bit
 *   dispatch allocation, writeback completion, retire and flush
 *   combinational read of both head slots
 */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_entry_array (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              alloc_en,
	input  logic [1:0]                        disp_count,
	input  logic [`ROB_TAG_W-1:0]             disp_tag0,
	input  logic [`ROB_TAG_W-1:0]             disp_tag1,
	input  rob_entry_pkg::op_class_e          disp_op0,
	input  rob_entry_pkg::op_class_e          disp_op1,
	input  logic [`ROB_REG_W-1:0]             disp_dest0,
	input  logic [`ROB_REG_W-1:0]             disp_dest1,
	input  logic                              wb_valid,
	input  logic [`ROB_TAG_W-1:0]             wb_tag,
	input  logic [`ROB_DATA_W-1:0]            wb_value,
	input  logic                              wb_mispredict,
	input  logic [`ROB_TAG_W-1:0]             head_idx0,
	input  logic [`ROB_TAG_W-1:0]             head_idx1,
	input  rob_ctrl_pkg::commit_amt_t         commit_amt,
	input  logic                              flush,
	output rob_entry_pkg::entry_state_e       head_state0,
	output rob_entry_pkg::entry_state_e       head_state1,
	output rob_entry_pkg::op_class_e          head_op0,
	output rob_entry_pkg::op_class_e          head_op1,
	output logic                              head_mispredict0,
	output logic                              head_mispredict1,
	output logic [`ROB_REG_W-1:0]             head_dest0,
	output logic [`ROB_REG_W-1:0]             head_dest1,
	output logic [`ROB_DATA_W-1:0]            head_value0,
	output logic [`ROB_DATA_W-1:0]            head_value1
);

	localparam int ENTRIES = `ROB_ENTRIES;

	rob_entry_pkg::entry_state_e ent_state [0:ENTRIES-1];
	rob_entry_pkg::op_class_e    ent_op    [0:ENTRIES-1];
	logic [`ROB_REG_W-1:0]       ent_dest  [0:ENTRIES-1];
	logic [`ROB_DATA_W-1:0]      ent_value [0:ENTRIES-1];
	logic                        ent_mis   [0:ENTRIES-1];

	// ==================================================================
	// entry state
	// ==================================================================
	// retire, writeback and dispatch never touch the same entry in one
	// cycle, since each acts only on entries in a different state
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			for (int i = 0; i < ENTRIES; i++)
				ent_state[i] <= rob_entry_pkg::ent_free;
		end else begin
			// retired entries go back to the free pool
			if (commit_amt != '0)
				ent_state[head_idx0] <= rob_entry_pkg::ent_free;
			if (commit_amt == rob_ctrl_pkg::commit_amt_t'(2))
				ent_state[head_idx1] <= rob_entry_pkg::ent_free;
			// a result arrived so the entry may now retire
			if (wb_valid)
				ent_state[wb_tag] <= rob_entry_pkg::ent_done;
			// newly dispatched entries wait for their result
			if (alloc_en)
				ent_state[disp_tag0] <= rob_entry_pkg::ent_busy;
			if (alloc_en && disp_count == 2'd2)
				ent_state[disp_tag1] <= rob_entry_pkg::ent_busy;
		end
	end

	// ==================================================================
	// entry payload
	// ==================================================================
	// op class and destination are captured at dispatch
	// value and mispredict flag are captured at writeback
	always_ff @(posedge clk) begin
		if (alloc_en) begin
			ent_op[disp_tag0]   <= disp_op0;
			ent_dest[disp_tag0] <= disp_dest0;
		end
		if (alloc_en && disp_count == 2'd2) begin
			ent_op[disp_tag1]   <= disp_op1;
			ent_dest[disp_tag1] <= disp_dest1;
		end
		if (wb_valid) begin
			ent_value[wb_tag] <= wb_value;
			ent_mis[wb_tag]   <= wb_mispredict;
		end
	end

	// head slots are read straight out of the arrays
	assign head_state0      = ent_state[head_idx0];
	assign head_state1      = ent_state[head_idx1];
	assign head_op0         = ent_op[head_idx0];
	assign head_op1         = ent_op[head_idx1];
	assign head_mispredict0 = ent_mis[head_idx0];
	assign head_mispredict1 = ent_mis[head_idx1];
	assign head_dest0       = ent_dest[head_idx0];
	assign head_dest1       = ent_dest[head_idx1];
	assign head_value0      = ent_value[head_idx0];
	assign head_value1      = ent_value[head_idx1];

	// the producer may only complete entries that are still in flight
	a_wb_busy: assert property (
		@(posedge clk) disable iff (rst)
		wb_valid |-> ent_state[wb_tag] == rob_entry_pkg::ent_busy
	) else $error("writeback to an entry that is not busy");

endmodule

//--- hw/rob_entry_pkg.sv
/*
 * types that describe a single reorder buffer entry
 *   op_class_e     operation class recorded at dispatch
 *   entry_state_e  lifecycle of an entry slot
 */
package rob_entry_pkg;

	// operation class of the instruction held in an entry
	// the commit controller only cares about stores and branches
	typedef enum logic [1:0] {
		op_alu    = 2'd0,
		op_load   = 2'd1,
		op_store  = 2'd2,
		op_branch = 2'd3
	} op_class_e;

	// an entry is free until dispatched, busy until written back,
	// and done until it retires
	typedef enum logic [1:0] {
		ent_free = 2'd0,
		ent_busy = 2'd1,
		ent_done = 2'd2
	} entry_state_e;

endpackage

//--- hw/rob_head_ptrs.sv
/*
 * rob_head_ptrs
 *   one head index per commit lane, all advancing together by the
 *   number of entries retired in the cycle
 */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_head_ptrs (
	input  logic                        clk,
	input  logic                        rst,
	input  rob_ctrl_pkg::commit_amt_t   commit_amt,
	output logic [`ROB_TAG_W-1:0]       head_idx0,
	output logic [`ROB_TAG_W-1:0]       head_idx1
);

	localparam int TW      = `ROB_TAG_W;
	localparam int ENTRIES = `ROB_ENTRIES;
	localparam int SLOTS   = `ROB_WIDTH;

	// slot n always points n entries past the oldest instruction
	logic [TW-1:0] heads [0:SLOTS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < SLOTS; n++)
				heads[n] <= TW'(n);
		end else begin
			// every slot moves by the same amount so their spacing is kept
			for (int n = 0; n < SLOTS; n++)
				heads[n] <= TW'((int'(heads[n]) + int'(commit_amt)) % ENTRIES);
		end
	end

	assign head_idx0 = heads[0];
	assign head_idx1 = heads[1];

	// the second slot must always be the entry right after the first one
	a_heads_consecutive: assert property (
		@(posedge clk) disable iff (rst)
		head_idx1 == TW'(head_idx0 + 1'b1)
	) else $error("head slots are no longer consecutive");

endmodule

//--- hw/rob_tail_ptrs.sv
/*
 * rob_tail_ptrs
 *   allocation tail pointer and occupancy count
 *   dispatch readiness and the tags handed to a dispatch group
 */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_tail_ptrs (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        disp_valid,
	input  logic [1:0]                  disp_count,
	input  rob_ctrl_pkg::commit_amt_t   commit_amt,
	input  logic                        flush,
	input  logic [`ROB_TAG_W-1:0]       head_idx0,
	output logic                        disp_ready,
	output logic [`ROB_TAG_W-1:0]       disp_tag0,
	output logic [`ROB_TAG_W-1:0]       disp_tag1,
	output logic                        alloc_en
);

	localparam int TW    = `ROB_TAG_W;
	localparam int CNT_W = `ROB_TAG_W + 1;

	logic [TW-1:0]    tail;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] add_amt;

	// a full group must fit, and nothing is accepted while flushing
	assign disp_ready = !flush && (count <= CNT_W'(`ROB_ENTRIES - `ROB_WIDTH));
	assign alloc_en   = disp_valid && disp_ready;

	// tags are simply the next free slots after the tail
	assign disp_tag0 = tail;
	assign disp_tag1 = tail + TW'(1);

	assign add_amt = alloc_en ? CNT_W'(disp_count) : '0;

	// ==================================================================
	// tail and count registers
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			tail  <= '0;
			count <= '0;
		end else if (flush) begin
			// everything younger than the head is thrown away
			tail  <= head_idx0;
			count <= '0;
		end else begin
			tail  <= tail + TW'(add_amt);
			count <= count + add_amt - CNT_W'(commit_amt);
		end
	end

	// the occupancy may reach the entry count but never pass it
	a_count_bound: assert property (
		@(posedge clk) disable iff (rst)
		count <= CNT_W'(`ROB_ENTRIES)
	) else $error("ROB occupancy count overflowed");

endmodule

//--- hw/rob_top.sv
/*
 * rob_top
 *   reorder buffer top level
 *   head pointers, tail pointers, entry array and commit controller
 */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_top (
	input  logic                          clk,
	input  logic                          rst,
	// dispatch channel
	input  logic                          disp_valid,
	input  logic [1:0]                    disp_count,
	input  rob_entry_pkg::op_class_e      disp_op0,
	input  rob_entry_pkg::op_class_e      disp_op1,
	input  logic [`ROB_REG_W-1:0]         disp_dest0,
	input  logic [`ROB_REG_W-1:0]         disp_dest1,
	output logic                          disp_ready,
	output logic [`ROB_TAG_W-1:0]         disp_tag0,
	output logic [`ROB_TAG_W-1:0]         disp_tag1,
	// writeback channel
	input  logic                          wb_valid,
	input  logic [`ROB_TAG_W-1:0]         wb_tag,
	input  logic [`ROB_DATA_W-1:0]        wb_value,
	input  logic                          wb_mispredict,
	// retire channel
	output logic [`ROB_WIDTH-1:0]         commit_valid,
	input  logic                          commit_ready,
	output rob_entry_pkg::op_class_e      commit_op0,
	output rob_entry_pkg::op_class_e      commit_op1,
	output logic [`ROB_REG_W-1:0]         commit_dest0,
	output logic [`ROB_REG_W-1:0]         commit_dest1,
	output logic [`ROB_DATA_W-1:0]        commit_value0,
	output logic [`ROB_DATA_W-1:0]        commit_value1
);

	rob_ctrl_pkg::commit_amt_t    commit_amt;
	logic                         flush;
	logic                         alloc_en;
	logic [`ROB_TAG_W-1:0]        head_idx0;
	logic [`ROB_TAG_W-1:0]        head_idx1;
	rob_entry_pkg::entry_state_e  head_state0;
	rob_entry_pkg::entry_state_e  head_state1;
	logic                         head_mispredict0;
	logic                         head_mispredict1;

	rob_head_ptrs u_head (
		.clk        (clk),
		.rst        (rst),
		.commit_amt (commit_amt),
		.head_idx0  (head_idx0),
		.head_idx1  (head_idx1)
	);

	rob_tail_ptrs u_tail (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.disp_count (disp_count),
		.commit_amt (commit_amt),
		.flush      (flush),
		.head_idx0  (head_idx0),
		.disp_ready (disp_ready),
		.disp_tag0  (disp_tag0),
		.disp_tag1  (disp_tag1),
		.alloc_en   (alloc_en)
	);

	// the head outputs feed both the controller and the retire port
	rob_entry_array u_array (
		.clk              (clk),
		.rst              (rst),
		.alloc_en         (alloc_en),
		.disp_count       (disp_count),
		.disp_tag0        (disp_tag0),
		.disp_tag1        (disp_tag1),
		.disp_op0         (disp_op0),
		.disp_op1         (disp_op1),
		.disp_dest0       (disp_dest0),
		.disp_dest1       (disp_dest1),
		.wb_valid         (wb_valid),
		.wb_tag           (wb_tag),
		.wb_value         (wb_value),
		.wb_mispredict    (wb_mispredict),
		.head_idx0        (head_idx0),
		.head_idx1        (head_idx1),
		.commit_amt       (commit_amt),
		.flush            (flush),
		.head_state0      (head_state0),
		.head_state1      (head_state1),
		.head_op0         (commit_op0),
		.head_op1         (commit_op1),
		.head_mispredict0 (head_mispredict0),
		.head_mispredict1 (head_mispredict1),
		.head_dest0       (commit_dest0),
		.head_dest1       (commit_dest1),
		.head_value0      (commit_value0),
		.head_value1      (commit_value1)
	);

	rob_commit_ctrl u_ctrl (
		.clk              (clk),
		.rst              (rst),
		.head_state0      (head_state0),
		.head_state1      (head_state1),
		.head_op0         (commit_op0),
		.head_op1         (commit_op1),
		.head_mispredict0 (head_mispredict0),
		.head_mispredict1 (head_mispredict1),
		.commit_ready     (commit_ready),
		.commit_valid     (commit_valid),
		.commit_amt       (commit_amt),
		.flush            (flush)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module rob_tb -f filelist.f

# the simulator exits with a failing status on any $fatal
./obj_dir/Vrob_tb

//--- verification/rob_tb_model.svh
/*
 * reference model of the reorder buffer, included in the testbench top
 *   program-order queue of tags with per-tag payload
 *   expected commit group and dispatch readiness
 *   compare tasks for ops, values, destinations, lane counts, tags and flags
 */
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// tags of the instructions in flight, oldest first
logic [`ROB_TAG_W-1:0]    m_order [$];
rob_entry_pkg::op_class_e m_op    [0:`ROB_ENTRIES-1];
logic [`ROB_REG_W-1:0]    m_dest  [0:`ROB_ENTRIES-1];
logic [`ROB_DATA_W-1:0]   m_val   [0:`ROB_ENTRIES-1];
logic                     m_done  [0:`ROB_ENTRIES-1];
logic                     m_mis   [0:`ROB_ENTRIES-1];
logic [`ROB_TAG_W-1:0]    m_head  = '0;
logic [`ROB_TAG_W-1:0]    m_tail  = '0;
// high for the single cycle that follows a retired mispredicted branch
logic                     m_flush = 1'b0;

function automatic bit is_bad_branch(input logic [`ROB_TAG_W-1:0] tag);
	return (m_op[tag] == rob_entry_pkg::op_branch) && m_mis[tag];
endfunction

// room for a full group is needed before a dispatch is taken
function automatic bit model_ready();
	return !m_flush && (m_order.size() <= `ROB_ENTRIES - `ROB_WIDTH);
endfunction

// number of lanes the head may retire in the current cycle
function automatic int model_group();
	if (m_flush || m_order.size() == 0 || !m_done[m_order[0]])
		return 0;
	// a bad branch ends its group
	if (m_order.size() < 2 || !m_done[m_order[1]] || is_bad_branch(m_order[0]))
		return 1;
	// two stores never leave together
	if (m_op[m_order[0]] == rob_entry_pkg::op_store &&
			m_op[m_order[1]] == rob_entry_pkg::op_store)
		return 1;
	return 2;
endfunction

task automatic add_entry(input rob_entry_pkg::op_class_e op,
		input logic [`ROB_REG_W-1:0] dest);
	m_order.push_back(m_tail);
	m_op[m_tail] = op;
	m_dest[m_tail] = dest;
	m_done[m_tail] = 1'b0;
	m_tail = m_tail + `ROB_TAG_W'(1);
endtask

// ======================================================================
// compare tasks
// ======================================================================
task automatic check_commit_op(input rob_entry_pkg::op_class_e got,
		input rob_entry_pkg::op_class_e exp, input string what);
	if (got !== exp)
		stop_run($sformatf("ERR %0t: %s got %s expected %s",
			$time, what, got.name(), exp.name()));
endtask

task automatic check_value(input logic [`ROB_DATA_W-1:0] got,
		input logic [`ROB_DATA_W-1:0] exp, input string what);
	if (got !== exp)
		stop_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
endtask

task automatic check_dest(input logic [`ROB_REG_W-1:0] got,
		input logic [`ROB_REG_W-1:0] exp, input string what);
	if (got !== exp)
		stop_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
endtask

task automatic check_count(input int got, input int exp, input string what);
	if (got != exp)
		stop_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
endtask

task automatic check_tag(input logic [`ROB_TAG_W-1:0] got,
		input logic [`ROB_TAG_W-1:0] exp, input string what);
	if (got !== exp)
		stop_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp)
		stop_run($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, exp));
endtask

`endif

//--- verification/rob_tb.sv
/*
 * testbench top for the reorder buffer
 *   clock, reset and random dispatch, writeback and retire stimulus
 *   cycle by cycle comparison against the included model
 *   watchdog sized from the transaction count
 */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_tb;

	localparam int N_TXN  = 3000;
	localparam int CLK_NS = 10;
	// each dispatched instruction is allowed up to 40 cycles on average
	localparam longint WATCHDOG_NS = longint'(N_TXN) * 40 * CLK_NS;

	logic                         clk = 1'b0;
	logic                         rst;
	logic                         disp_valid;
	logic [1:0]                   disp_count;
	rob_entry_pkg::op_class_e     disp_op0;
	rob_entry_pkg::op_class_e     disp_op1;
	logic [`ROB_REG_W-1:0]        disp_dest0;
	logic [`ROB_REG_W-1:0]        disp_dest1;
	logic                         disp_ready;
	logic [`ROB_TAG_W-1:0]        disp_tag0;
	logic [`ROB_TAG_W-1:0]        disp_tag1;
	logic                         wb_valid;
	logic [`ROB_TAG_W-1:0]        wb_tag;
	logic [`ROB_DATA_W-1:0]       wb_value;
	logic                         wb_mispredict;
	logic [`ROB_WIDTH-1:0]        commit_valid;
	logic                         commit_ready;
	rob_entry_pkg::op_class_e     commit_op0;
	rob_entry_pkg::op_class_e     commit_op1;
	logic [`ROB_REG_W-1:0]        commit_dest0;
	logic [`ROB_REG_W-1:0]        commit_dest1;
	logic [`ROB_DATA_W-1:0]       commit_value0;
	logic [`ROB_DATA_W-1:0]       commit_value1;

	int sent       = 0;
	int stall      = 0;
	int full_seen  = 0;
	int flush_seen = 0;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "run stopped after a failure");
	endtask

	`include "rob_tb_model.svh"

	rob_top u_dut (.*);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic rob_entry_pkg::op_class_e rand_op();
		return rob_entry_pkg::op_class_e'(2'($urandom_range(0, 3)));
	endfunction

	// ==================================================================
	// per-cycle checks, run mid-cycle when all outputs have settled
	// ==================================================================
	task automatic check_cycle();
		int n;
		int got;
		n = model_group();
		got = (commit_valid == 2'b00) ? 0 : (commit_valid == 2'b01) ? 1 :
			(commit_valid == 2'b11) ? 2 : -1;
		check_count(got, n, "commit lanes");
		check_flag(disp_ready, model_ready(), "disp_ready");
		// after a flush the next tag must equal the head past the branch
		check_tag(disp_tag0, m_tail, "disp_tag0");
		check_tag(disp_tag1, m_tail + `ROB_TAG_W'(1), "disp_tag1");
		if (n > 0) begin
			check_commit_op(commit_op0, m_op[m_order[0]], "commit_op0");
			check_dest(commit_dest0, m_dest[m_order[0]], "commit_dest0");
			check_value(commit_value0, m_val[m_order[0]], "commit_value0");
		end
		if (n > 1) begin
			check_commit_op(commit_op1, m_op[m_order[1]], "commit_op1");
			check_dest(commit_dest1, m_dest[m_order[1]], "commit_dest1");
			check_value(commit_value1, m_val[m_order[1]], "commit_value1");
		end
		if (!m_flush && !disp_ready)
			full_seen++;
	endtask

	// moves the model by what the coming clock edge will do
	task automatic advance_model();
		logic [`ROB_TAG_W-1:0] t;
		int n;
		bit rdy;
		bit bad;
		n = model_group();
		rdy = model_ready();
		bad = 1'b0;
		if (m_flush) begin
			// every younger entry is gone and the tail snaps to the head
			m_order.delete();
			m_tail = m_head;
			m_flush = 1'b0;
		end else begin
			if (commit_ready) begin
				for (int i = 0; i < n; i++) begin
					t = m_order.pop_front();
					bad = is_bad_branch(t);
				end
				m_head = m_head + `ROB_TAG_W'(n);
			end
			if (wb_valid) begin
				m_done[wb_tag] = 1'b1;
				m_val[wb_tag] = wb_value;
				m_mis[wb_tag] = wb_mispredict;
			end
			if (disp_valid && rdy) begin
				add_entry(disp_op0, disp_dest0);
				if (disp_count == 2'd2)
					add_entry(disp_op1, disp_dest1);
				sent += int'(disp_count);
			end
			if (bad) begin
				m_flush = 1'b1;
				flush_seen++;
			end
		end
	endtask

	task automatic drive_inputs();
		logic [`ROB_TAG_W-1:0] busy [$];
		foreach (m_order[i])
			if (!m_done[m_order[i]])
				busy.push_back(m_order[i]);
		disp_valid <= (sent < N_TXN) && ($urandom_range(0, 3) != 0);
		disp_count <= 2'($urandom_range(1, 2));
		disp_op0 <= rand_op();
		disp_op1 <= rand_op();
		disp_dest0 <= `ROB_REG_W'($urandom);
		disp_dest1 <= `ROB_REG_W'($urandom);
		// results come back in random order for any tag still in flight
		wb_valid <= !m_flush && (busy.size() > 0) && ($urandom_range(0, 3) != 0);
		if (busy.size() > 0)
			wb_tag <= busy[$urandom_range(0, busy.size() - 1)];
		wb_value <= $urandom;
		wb_mispredict <= ($urandom_range(0, 5) == 0);
		// long stretches of back-pressure let the buffer fill up
		if (stall > 0)
			stall--;
		else if ($urandom_range(0, 39) == 0)
			stall = $urandom_range(20, 40);
		commit_ready <= (stall == 0) && ($urandom_range(0, 4) != 0);
	endtask

	// ==================================================================
	// main sequence
	// ==================================================================
	initial begin
		void'($urandom(32'h9101_2114));
		rst <= 1'b1;
		disp_valid <= 1'b0;
		disp_count <= 2'd1;
		disp_op0 <= rob_entry_pkg::op_alu;
		disp_op1 <= rob_entry_pkg::op_alu;
		disp_dest0 <= '0;
		disp_dest1 <= '0;
		wb_valid <= 1'b0;
		wb_tag <= '0;
		wb_value <= '0;
		wb_mispredict <= 1'b0;
		commit_ready <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		while (sent < N_TXN || m_order.size() != 0 || m_flush) begin
			@(negedge clk);
			check_cycle();
			advance_model();
			@(posedge clk);
			drive_inputs();
		end
		if (full_seen == 0 || flush_seen == 0)
			stop_run("the run never filled the buffer or never saw a flush");
		else begin
			$display("all tests passed");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired because the test did not finish in time");
	end

endmodule
